// ==== ksCpu.f ====
+incdir+.
+incdir+testbench
verilog/cpuPkg.sv
verilog/instDecode.sv
verilog/aluUnit.sv
verilog/cpuSequencer.sv
verilog/acFile.sv
verilog/ksCpu.sv
testbench/ksCpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the ksCpu testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
   --top-module ksCpuTb -f ksCpu.f

simOut=$(./obj_dir/VksCpuTb)
echo "$simOut"

if grep -qF "*** TEST PASSED ***" <<< "$simOut"; then
   exit 0
fi
exit 1

// ==== testbench/ksCpuModel.svh ====
// Instruction-level reference model and random source for the processor testbench
// Included inside the testbench module, works on its own copy of the memory image

`ifndef KS_CPU_MODEL_SVH
`define KS_CPU_MODEL_SVH

logic [31:0] lfsrState = 32'd46;                // Seed

// Galois LFSR, stepped once per bit taken
function automatic logic [35:0] randBits(input int n);
   logic [35:0] v;
   v = '0;
   for (int k = 0; k < n; k++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
      v = {v[34:0], lfsrState[0]};
   end
   return v;
endfunction

////////////////////
// Model state
////////////////////

logic [35:0] modelMem [256];
logic [35:0] modelAcs [16];
bit          expWrite [$];                      // 0 read, 1 write
logic [17:0] expAddr  [$];
logic [35:0] expData  [$];                      // Only meaningful for writes

task automatic expectCycle(input bit isWrite, input logic [17:0] addr, input logic [35:0] data);
   expWrite.push_back(isWrite);
   expAddr.push_back(addr);
   expData.push_back(data);
endtask

// Runs from startPc up to a HALT, gives back the PC past it
task automatic modelRun(input logic [17:0] startPc, output logic [17:0] haltPc);
   logic [17:0] pc;
   logic [35:0] inst;
   logic [8:0]  opc;
   logic [3:0]  ac;
   logic [17:0] y;
   logic [35:0] opnd;
   bit          halted;
   pc = startPc;
   halted = 1'b0;
   while (!halted) begin
      inst = modelMem[pc[7:0]];
      expectCycle(1'b0, pc, '0);                 // Fetch
      opc = inst[35:27];
      ac  = inst[26:23];
      y   = inst[17:0];                          // I and XR play no part
      pc  = pc + 18'd1;
      case (opc)
         `OP_MOVE, `OP_ADD, `OP_SUB, `OP_AND, `OP_IOR, `OP_XOR: begin
            opnd = modelMem[y[7:0]];
            expectCycle(1'b0, y, '0);           // Operand read
            case (opc)
               `OP_MOVE: modelAcs[ac] = opnd;
               `OP_ADD:  modelAcs[ac] = modelAcs[ac] + opnd;   // Wraps at 2**36
               `OP_SUB:  modelAcs[ac] = modelAcs[ac] - opnd;
               `OP_AND:  modelAcs[ac] = modelAcs[ac] & opnd;
               `OP_IOR:  modelAcs[ac] = modelAcs[ac] | opnd;
               default:  modelAcs[ac] = modelAcs[ac] ^ opnd;
            endcase
         end
         `OP_MOVEM: begin
            modelMem[y[7:0]] = modelAcs[ac];
            expectCycle(1'b1, y, modelAcs[ac]);
         end
         `OP_JUMPE: begin
            if (modelAcs[ac] == '0)
               pc = y;
         end
         `OP_JRST: begin
            if (ac != '0)
               halted = 1'b1;                    // HALT, PC already past it
            else
               pc = y;
         end
         default: ;                              // Unknown opcode
      endcase
   end
   haltPc = pc;
endtask

`endif

// ==== testbench/ksCpuTb.sv ====
// Self-checking testbench for the processor: random programs, memory waits, console pulses
// Every bus cycle is compared in order with the model from ksCpuModel.svh

`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module ksCpuTb import cpuPkg::*; ();

   localparam int NUM_TESTS       = 8;
   localparam int CYCLES_PER_TEST = 400;         // Two passes of 14 instructions, slow memory
   localparam int BODY            = 12;          // Instructions ahead of the HALT pair
   localparam int PULSE_RUN       = 0;
   localparam int PULSE_HALT      = 1;
   localparam int PULSE_CONT      = 2;

   logic clk;
   logic reset;
   logic consRun;
   logic consHalt;
   logic consCont;
   wordT cpuDin = '0;
   logic memAck = 1'b0;
   addrT cpuAddr;
   wordT cpuDout;
   logic cpuRead;
   logic cpuWrite;
   logic cpuRun;
   logic cpuHalt;

   wordT mem [256];                              // Memory image seen by the DUT
   int   expIdx;                                 // Next expected bus cycle
   int   errors = 0;
   int   checks = 0;
   int   waitLeft;                               // Responder wait countdown
   logic holdActive;                             // Strobe up, not yet acked
   addrT holdAddr;
   wordT holdDout;
   logic holdRead;
   logic stopWatch = 1'b0;                       // consHalt already seen by the DUT
   int   stopStrobes;                            // Strobes raised since then

   `include "ksCpuModel.svh"

   ksCpu ksCpu_i (
      .clk(clk), .reset(reset),
      .consRun(consRun), .consHalt(consHalt), .consCont(consCont),
      .cpuDin(cpuDin), .memAck(memAck),
      .cpuAddr(cpuAddr), .cpuDout(cpuDout), .cpuRead(cpuRead), .cpuWrite(cpuWrite),
      .cpuRun(cpuRun), .cpuHalt(cpuHalt)
   );

   always #10 clk = ~clk;                        // 20 ns period

   task automatic check(input string name, input logic [35:0] expected,
                        input logic [35:0] actual);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   ////////////////////
   // Memory responder
   ////////////////////

   always @(posedge clk) begin
      if (reset) begin
         memAck <= 1'b0;
         waitLeft = -1;
      end else if (memAck) begin
         memAck <= 1'b0;                         // Ack edge, cycle done
         waitLeft = -1;
         if (expIdx >= expAddr.size()) begin
            errors++;
            $display("Unexpected bus cycle at address %h after the model's last one", cpuAddr);
         end else begin
            check("cpuWrite", 36'(expWrite[expIdx]), 36'(cpuWrite));
            check("cpuAddr", 36'(expAddr[expIdx]), 36'(cpuAddr));
            if (cpuWrite)
               check("cpuDout", expData[expIdx], cpuDout);
            expIdx++;
         end
         if (cpuWrite)
            mem[cpuAddr[7:0]] = cpuDout;
      end else if (cpuRead || cpuWrite) begin
         if (waitLeft < 0)
            waitLeft = int'(randBits(2));        // 0 to 3 wait cycles
         if (waitLeft == 0) begin
            memAck <= 1'b1;
            cpuDin <= mem[cpuAddr[7:0]];
         end else begin
            waitLeft--;
         end
      end
   end

   // Strobe, address and data hold from the rise to the ack edge
   always @(posedge clk) begin
      if (reset) begin
         holdActive = 1'b0;
      end else begin
         check("cpuRead & cpuWrite", '0, 36'(cpuRead & cpuWrite));
         if (holdActive) begin
            check("held cpuAddr", 36'(holdAddr), 36'(cpuAddr));
            check("held cpuDout", holdDout, cpuDout);
            check("held cpuRead", 36'(holdRead), 36'(cpuRead));
            check("held cpuWrite", 36'(!holdRead), 36'(cpuWrite));
         end
         if (memAck) begin
            holdActive = 1'b0;
         end else if (!holdActive && (cpuRead || cpuWrite)) begin
            holdActive = 1'b1;
            holdAddr   = cpuAddr;
            holdDout   = cpuDout;
            holdRead   = cpuRead;
            if (stopWatch)
               stopStrobes++;                    // Rise after the stop request
         end
      end
   end

   ////////////////////
   // Stimulus helpers
   ////////////////////

   task automatic applyReset();
      @(posedge clk);
      reset <= 1'b1;
      repeat (8) @(posedge clk);
      reset <= 1'b0;
   endtask

   // One-cycle console pulse
   task automatic consolePulse(input int which);
      @(posedge clk);
      case (which)
         PULSE_RUN:  consRun <= 1'b1;
         PULSE_HALT: consHalt <= 1'b1;
         default:    consCont <= 1'b1;
      endcase
      @(posedge clk);
      consRun  <= 1'b0;
      consHalt <= 1'b0;
      consCont <= 1'b0;
   endtask

   task automatic waitHalted();
      do
         @(posedge clk);
      while (!cpuHalt);
      check("cpuRun", '0, 36'(cpuRun));
   endtask

   // Halted and quiet for n cycles
   task automatic expectIdle(input int n);
      repeat (n) begin
         @(posedge clk);
         check("cpuHalt", 36'd1, 36'(cpuHalt));
         check("cpuRun", '0, 36'(cpuRun));
         check("cpuRead", '0, 36'(cpuRead));
         check("cpuWrite", '0, 36'(cpuWrite));
      end
   endtask

   // 0..7 straight-line ops, 8..15 add jumps and unknown opcodes
   function automatic logic [8:0] opcodeFor(input logic [3:0] sel);
      case (sel)
         4'd0, 4'd8:   return `OP_MOVE;
         4'd1, 4'd7:   return `OP_MOVEM;
         4'd2, 4'd9:   return `OP_ADD;
         4'd3:         return `OP_SUB;
         4'd4:         return `OP_AND;
         4'd5:         return `OP_IOR;
         4'd6:         return `OP_XOR;
         4'd10, 4'd11: return `OP_JUMPE;
         4'd12:        return `OP_JRST;
         4'd13:        return 9'o000;           // Outside the subset
         4'd14:        return 9'o777;
         default:      return 9'o124;
      endcase
   endfunction

   task automatic genProgram(input bit mixed);
      logic [3:0]  sel;
      logic [8:0]  opc;
      logic [3:0]  ac;
      logic [4:0]  ixr;
      logic [17:0] y;
      logic [7:0]  a;
      for (int i = 0; i < 256; i++) begin
         a = 8'(i);
         if (i >= 128)
            mem[i] = randBits(36);              // Data area
         else
            mem[i] = {4'h0, a, a, ~a, a};        // Unused code area
      end
      for (int i = 0; i < BODY; i++) begin
         sel = mixed ? 4'(randBits(4)) : 4'(randBits(3));
         opc = opcodeFor(sel);
         ac  = 4'(randBits(4));
         ixr = 5'(randBits(5));                  // I and XR, ignored
         if (opc == `OP_JUMPE || opc == `OP_JRST)
            y = 18'(i + 1 + int'(randBits(8)) % (BODY - i));   // Forward, at most the HALT
         else
            y = {10'h0, 1'b1, 7'(randBits(7))};
         if (opc == `OP_JRST)
            ac = '0;                             // Jump, not HALT
         mem[i] = {opc, ac, ixr, y};
      end
      // HALT, then a second one for the consCont fetch
      for (int i = BODY; i < BODY + 2; i++)
         mem[i] = {`OP_JRST, 4'(1 + randBits(3)), 5'h0, 18'(randBits(18))};
      for (int i = 0; i < 256; i++)
         modelMem[i] = mem[i];
      for (int i = 0; i < 16; i++)
         modelAcs[i] = '0;
      expWrite.delete();
      expAddr.delete();
      expData.delete();
      expIdx = 0;
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      logic [17:0] haltPc;
      int          firstLen;
      int          stops;
      int          errorsBefore;
      clk      = 1'b0;
      reset    = 1'b1;
      consRun  = 1'b0;
      consHalt = 1'b0;
      consCont = 1'b0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         errorsBefore = errors;
         genProgram(t % 2 == 1);                 // Odd tests mix in control flow
         modelRun(`RESET_PC, haltPc);
         firstLen = expAddr.size();
         modelRun(haltPc, haltPc);               // consCont onto the second HALT
         modelRun(`RESET_PC, haltPc);            // consRun, second pass
         applyReset();
         expectIdle(4);                          // No strobe before consRun
         consolePulse(PULSE_RUN);
         repeat (2 + int'(randBits(5))) @(posedge clk);
         stopStrobes = 0;
         consolePulse(PULSE_HALT);               // No effect once HALT is done
         stopWatch <= 1'b1;
         waitHalted();
         stopWatch <= 1'b0;
         // Only the current instruction's operand cycle may still start
         check("strobes after consHalt > 1", '0, 36'(stopStrobes > 1));
         stops = 0;
         while (expIdx < firstLen) begin        // Stopped ahead of the HALT
            stops++;
            expectIdle(3);
            consolePulse(PULSE_CONT);
            waitHalted();
         end
         expectIdle(4);
         consolePulse(PULSE_CONT);               // Next fetch at HALT + 1
         waitHalted();
         consolePulse(PULSE_RUN);                // Next fetch at RESET_PC
         waitHalted();
         check("bus cycle count", 36'(expAddr.size()), 36'(expIdx));
         $display("Test %0d %s: %0d bus cycles, %0d console stops, %0d errors",
                  t, (t % 2 == 1) ? "mixed" : "straight", expIdx, stops,
                  errors - errorsBefore);
      end
      $display("Tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

   // Watchdog
   initial begin
      #(NUM_TESTS * CYCLES_PER_TEST * 20);
      $display("Timeout: the processor did not halt within %0d cycles per test",
               CYCLES_PER_TEST);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog/ksCpu.sv ====
// Top level of the small 36-bit processor
// Connects sequencer, decoder, ALU and AC file to the memory and console ports

`timescale 1ns/100ps
`default_nettype none

module ksCpu import cpuPkg::*; (
   input  logic clk,
   input  logic reset,
   input  logic consRun,
   input  logic consHalt,
   input  logic consCont,
   input  wordT cpuDin,                        // Memory read data
   input  logic memAck,                        // Memory cycle done
   output addrT cpuAddr,
   output wordT cpuDout,
   output logic cpuRead,
   output logic cpuWrite,
   output logic cpuRun,
   output logic cpuHalt
);

   cpuOpT op;                                  // Decoded operation
   acNumT acNum;
   addrT  addrY;
   wordT  acValue;
   wordT  operand;                             // Operand register
   wordT  result;                              // ALU output
   logic  jumpTaken;
   logic  irLoad;
   logic  acWrite;

   ////////////////////
   // Control
   ////////////////////

   cpuSequencer uSequencer (
      .clk(clk), .reset(reset),
      .consRun(consRun), .consHalt(consHalt), .consCont(consCont),
      .memAck(memAck), .cpuDin(cpuDin),
      .op(op), .addrY(addrY), .jumpTaken(jumpTaken), .acValue(acValue),
      .cpuAddr(cpuAddr), .cpuRead(cpuRead), .cpuWrite(cpuWrite), .cpuDout(cpuDout),
      .operand(operand), .irLoad(irLoad), .acWrite(acWrite),
      .cpuRun(cpuRun), .cpuHalt(cpuHalt)
   );

   instDecode uDecode (
      .clk(clk), .reset(reset),
      .irLoad(irLoad), .cpuDin(cpuDin),
      .op(op), .acNum(acNum), .addrY(addrY)
   );

   ////////////////////
   // Datapath
   ////////////////////

   aluUnit uAlu (
      .op(op), .acValue(acValue), .operand(operand), .result(result)
   );

   acFile uAcFile (
      .clk(clk), .reset(reset),
      .acWrite(acWrite), .acNum(acNum), .result(result),
      .acValue(acValue), .jumpTaken(jumpTaken)
   );

endmodule

`default_nettype wire

// ==== verilog/acFile.sv ====
// Sixteen accumulators with write-back from the ALU
// Read is asynchronous, the zero test feeds the JUMPE decision

`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module acFile import cpuPkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  acWrite,                      // Execute cycle write-back
   input  acNumT acNum,                        // AC field of the IR
   input  wordT  result,                       // ALU result
   output wordT  acValue,
   output logic  jumpTaken                     // Addressed AC is zero
);

   ////////////////////
   // Storage
   ////////////////////

   wordT acRegs [`NUM_ACS];

   // All ACs start at zero
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NUM_ACS; i++)
            acRegs[i] <= '0;
      end else if (acWrite) begin
         acRegs[acNum] <= result;
      end
   end

   ////////////////////
   // Read side
   ////////////////////

   assign acValue = acRegs[acNum];              // Also the MOVEM store data

   // Only looked at by the sequencer for JUMPE
   assign jumpTaken = (acValue == '0);

endmodule

`default_nettype wire

// ==== verilog/cpuSequencer.sv ====
// Run/halt control, PC and memory cycle state machine
// Drives the read/write strobes and holds them until memAck

`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module cpuSequencer import cpuPkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  consRun,                      // Start at RESET_PC
   input  logic  consHalt,                     // Stop at next boundary
   input  logic  consCont,                     // Resume at PC
   input  logic  memAck,                       // Ends the current strobe
   input  wordT  cpuDin,                       // Read data for the operand
   input  cpuOpT op,
   input  addrT  addrY,
   input  logic  jumpTaken,                    // AC is zero
   input  wordT  acValue,                      // Data for MOVEM
   output addrT  cpuAddr,
   output logic  cpuRead,
   output logic  cpuWrite,
   output wordT  cpuDout,
   output wordT  operand,                      // To the ALU
   output logic  irLoad,
   output logic  acWrite,
   output logic  cpuRun,
   output logic  cpuHalt
);

   seqStateT state;
   seqStateT decodeNext;                       // Step after decode
   seqStateT boundary;                         // Step after an instruction
   addrT     pc;
   logic     haltReq;                          // consHalt seen while running
   logic     operandLoad;
   logic     isDataOp;                         // Needs operand read and AC write
   logic     jumpLoad;                         // PC <- Y on exec

   assign isDataOp = (op == opMove) || (op == opAdd) || (op == opSub) ||
                     (op == opAnd)  || (op == opIor) || (op == opXor);
   assign jumpLoad = (op == opJrst) || ((op == opJumpe) && jumpTaken);

   always_comb begin
      if (isDataOp)
         decodeNext = stRead;
      else if (op == opMovem)
         decodeNext = stWrite;
      else
         decodeNext = stExec;                   // Jumps, HALT, no-op
   end

   // Pending stop takes effect before the next fetch strobe
   assign boundary = (haltReq || consHalt) ? stHalted : stFetch;

   ////////////////////
   // State and PC
   ////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= stHalted;
         pc      <= `RESET_PC;
         haltReq <= 1'b0;
      end else begin
         case (state)
            stHalted: begin
               haltReq <= 1'b0;
               if (consRun) begin
                  pc    <= `RESET_PC;
                  state <= stFetch;
               end else if (consCont) begin
                  state <= stFetch;             // Resume where PC points
               end
            end
            stFetch: begin
               if (memAck) begin
                  pc    <= pc + 1'b1;           // Past the fetched word
                  state <= stDecode;
               end
            end
            stDecode: state <= decodeNext;
            stRead:   if (memAck) state <= stExec;
            stWrite:  if (memAck) state <= boundary;
            stExec: begin
               if (jumpLoad)
                  pc <= addrY;
               state <= (op == opHalt) ? stHalted : boundary;
            end
            default: state <= stHalted;
         endcase
         if (consHalt && (state != stHalted))
            haltReq <= 1'b1;
      end
   end

   // Operand register, payload only
   assign operandLoad = (state == stRead) && memAck;

   always_ff @(posedge clk) begin
      if (operandLoad)
         operand <= cpuDin;
   end

   ////////////////////
   // Bus and control
   ////////////////////

   // Strobes follow the state, so they stay up until the ack edge
   assign cpuRead  = (state == stFetch) || (state == stRead);
   assign cpuWrite = (state == stWrite);
   assign cpuAddr  = (state == stFetch) ? pc : addrY;
   assign cpuDout  = acValue;                   // Stable, ACs only change on exec

   assign irLoad   = (state == stFetch) && memAck;
   assign acWrite  = (state == stExec) && isDataOp;

   assign cpuRun   = (state != stHalted);
   assign cpuHalt  = (state == stHalted);

endmodule

`default_nettype wire

// ==== verilog/aluUnit.sv ====
// 36-bit execute logic for MOVE and the arithmetic and logical instructions
// Pure combinational, the result goes back to the AC file on the execute cycle

`timescale 1ns/100ps
`default_nettype none

module aluUnit import cpuPkg::*; (
   input  cpuOpT op,                           // Decoded operation
   input  wordT  acValue,                      // Addressed AC
   input  wordT  operand,                      // Word read from Y
   output wordT  result
);

   ////////////////////
   // Arithmetic
   ////////////////////

   wordT sum;                                  // AC + operand
   wordT diff;                                 // AC - operand

   // Carries out of bit 35 are dropped, modulo 2**36
   assign sum  = acValue + operand;
   assign diff = acValue - operand;

   ////////////////////
   // Result select
   ////////////////////

   always_comb begin
      case (op)
         opMove  : result = operand;            // Straight load
         opAdd   : result = sum;
         opSub   : result = diff;
         opAnd   : result = acValue & operand;
         opIor   : result = acValue | operand;
         opXor   : result = acValue ^ operand;
         default : result = acValue;            // No write-back for these anyway
      endcase
   end

endmodule

`default_nettype wire

// ==== verilog/instDecode.sv ====
// Instruction register and opcode decode
// Loaded on the fetch acknowledge, holds op, AC and Y for the rest of the instruction

`timescale 1ns/100ps
`default_nettype none

`include "cpu_macros.svh"

module instDecode import cpuPkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  irLoad,                       // Fetch acknowledge
   input  wordT  cpuDin,                       // Fetched instruction word
   output cpuOpT op,
   output acNumT acNum,
   output addrT  addrY
);

   // Instruction fields, bit 35 is the MSB
   // I (bit 22) and XR (21..18) carry no meaning here, no indirection or indexing
   opcodeT opcodeIn;
   acNumT  acIn;
   addrT   yIn;
   cpuOpT  opIn;                               // Decode of the incoming word

   assign opcodeIn = cpuDin[35:27];
   assign acIn     = cpuDin[26:23];
   assign yIn      = cpuDin[17:0];

   ////////////////////
   // Opcode decode
   ////////////////////

   always_comb begin
      case (opcodeIn)
         `OP_MOVE  : opIn = opMove;
         `OP_MOVEM : opIn = opMovem;
         `OP_ADD   : opIn = opAdd;
         `OP_SUB   : opIn = opSub;
         `OP_AND   : opIn = opAnd;
         `OP_IOR   : opIn = opIor;
         `OP_XOR   : opIn = opXor;
         `OP_JUMPE : opIn = opJumpe;
         `OP_JRST  : opIn = (acIn != '0) ? opHalt : opJrst;  // AC picks HALT
         default   : opIn = opNone;             // Outside the subset
      endcase
   end

   // Operation register, back to no-op on reset
   always_ff @(posedge clk) begin
      if (reset) begin
         op <= opNone;
      end else if (irLoad) begin
         op <= opIn;
      end
   end

   // AC and Y fields
   always_ff @(posedge clk) begin
      if (irLoad) begin
         acNum <= acIn;
         addrY <= yIn;                          // Effective address, unmodified
      end
   end

endmodule

`default_nettype wire

// ==== verilog/cpuPkg.sv ====
// Shared types for the processor RTL
// Modules take these by a wildcard import in their header

`default_nettype none

`include "cpu_macros.svh"

package cpuPkg;

   ////////////////////
   // Vectors
   ////////////////////

   typedef logic [`WORD_WIDTH-1:0]   wordT;    // 36-bit data word
   typedef logic [`ADDR_WIDTH-1:0]   addrT;    // Address or Y field
   typedef logic [`OPCODE_WIDTH-1:0] opcodeT;  // Instruction opcode
   typedef logic [`AC_WIDTH-1:0]     acNumT;   // Accumulator number

   // Decoded operation, one per supported instruction
   typedef enum logic [3:0] {
      opNone,                                  // Unknown opcode, runs as no-op
      opMove,
      opMovem,
      opAdd,
      opSub,
      opAnd,
      opIor,
      opXor,
      opJumpe,
      opJrst,
      opHalt                                   // JRST with nonzero AC
   } cpuOpT;

   // Sequencer states
   typedef enum logic [2:0] {
      stHalted,                                // Waiting on console
      stFetch,                                 // Instruction read at PC
      stDecode,                                // IR valid, pick next step
      stRead,                                  // Operand read at Y
      stWrite,                                 // AC written to Y
      stExec                                   // AC write-back, jumps
   } seqStateT;

endpackage

`default_nettype wire

// ==== cpu_macros.svh ====
// Word widths, opcode values and the reset PC for the small KS-10 processor
// Included by the package, the RTL and the testbench

`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

////////////////////
// Widths
////////////////////

`define WORD_WIDTH    36                // Data word
`define ADDR_WIDTH    18                // Y field and PC
`define OPCODE_WIDTH  9                 // Bits 35..27 of the instruction
`define AC_WIDTH      4                 // Bits 26..23 of the instruction
`define NUM_ACS       16                // Accumulator count

`define RESET_PC      18'o000000        // First fetch after consRun

////////////////////
// Opcodes (octal)
////////////////////

`define OP_MOVE       9'o200            // AC <- C(E)
`define OP_MOVEM      9'o202            // C(E) <- AC
`define OP_ADD        9'o270
`define OP_SUB        9'o274
`define OP_AND        9'o404
`define OP_XOR        9'o430
`define OP_IOR        9'o434
`define OP_JUMPE      9'o322            // Jump if AC is zero
`define OP_JRST       9'o254            // HALT when AC field nonzero

`endif
